// File: rtl/uart_cfg.svh
// Build options for the UART transmit hub
// Parity mode, host queue depth and the alarm report tags
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Parity select: 0 even, 1 odd
`define UART_PARITY_ODD 1'b0

// Host byte queue depth, power of two only
`define UART_FIFO_DEPTH 8

// High nibble of a normal alarm report
`define UART_ALARM_TAG 4'hA

// High nibble when an earlier report was overwritten
`define UART_OVERRUN_TAG 4'hE

`endif

// File: rtl/uart_frame_pkg.sv
// Line-level types for the serializer
// Frame word layout and serializer FSM states
package uart_frame_pkg;

    // Start + 8 data + parity + stop
    localparam int FRAME_BITS = 11;

    // Bit 0 goes out first, so start sits at the bottom
    typedef struct packed {
        logic       stop;    // Always 1
        logic       parity;  // Even or odd per config
        logic [7:0] data;    // Sent LSB first
        logic       start;   // Always 0
    } frame_word_t;

    // Serializer FSM
    typedef enum logic {
        SER_IDLE  = 1'b0,   // Line high, waiting for a start
        SER_SHIFT = 1'b1    // Frame on the line
    } ser_state_t;

endpackage

// File: rtl/uart_port_pkg.sv
// Bus-level types shared by the sources, the arbiter and the serializer
// Byte request struct, source identifier and grant vector
package uart_port_pkg;

    // One byte offered for transmission
    typedef struct packed {
        logic       valid;  // Offer present
        logic [7:0] data;   // Byte to send
    } tx_req_t;

    // Which source owns a byte
    typedef enum logic {
        SRC_HOST  = 1'b0,   // Host byte queue
        SRC_ALARM = 1'b1    // Alarm reporter
    } src_id_t;

    // One-cycle grant pulse, indexed by src_id_t
    typedef logic [1:0] grant_t;

endpackage

// File: rtl/tx_fifo.sv
// Host byte queue, circular buffer with write and read pointers
// Write strobe with full level in, head offered as a tx request out
`include "uart_cfg.svh"

module tx_fifo (
    input  logic                   baud_clk,
    input  logic                   arst_n,
    input  logic [7:0]             host_data,
    input  logic                   host_wr,
    input  logic                   pop,
    output uart_port_pkg::tx_req_t fifo_req,
    output logic                   host_full
);
    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = DEPTH[AW:0];

    logic [7:0]    mem [DEPTH];   // Byte storage
    logic [AW-1:0] wr_ptr;        // Next free slot
    logic [AW-1:0] rd_ptr;        // Head of queue
    logic [AW:0]   count;         // Occupancy, one extra bit for full
    logic          wr_en;         // Accepted write

    assign wr_en     = host_wr && !host_full;  // Writes while full are dropped
    assign host_full = (count == FULL_CNT);

    assign fifo_req.valid = (count != '0);
    assign fifo_req.data  = mem[rd_ptr];       // Head shown before the pop

    always_ff @(posedge baud_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= host_data;
        end
    end

    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous write and pop leave count unchanged
            unique case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Grant only reaches a source that is offering a byte
    a_no_pop_when_empty: assert property (
        @(posedge baud_clk) disable iff (!arst_n)
        pop |-> fifo_req.valid
    ) else $error("tx_fifo: pop while empty");

endmodule

// File: rtl/alarm_reporter.sv
// Alarm reporter, turns alarm pulses into one-byte reports
// Keeps the latest code and flags overwritten reports as overrun
`include "uart_cfg.svh"

module alarm_reporter (
    input  logic                   baud_clk,
    input  logic                   arst_n,
    input  logic                   alarm,
    input  logic [3:0]             alarm_code,
    input  logic                   pop,
    output uart_port_pkg::tx_req_t alarm_req
);
    logic       pending;   // Report waiting for the line
    logic       overrun;   // A pending report was overwritten
    logic [3:0] code;      // Latest alarm code
    logic [3:0] tag;       // Report high nibble

    assign tag = overrun ? `UART_OVERRUN_TAG : `UART_ALARM_TAG;

    assign alarm_req.valid = pending;
    assign alarm_req.data  = {tag, code};

    // Code is payload, qualified by pending
    always_ff @(posedge baud_clk) begin
        if (alarm) begin
            code <= alarm_code;   // Newest code always wins
        end
    end

    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (alarm) begin
                pending <= 1'b1;
                // Pop in the same cycle means a fresh report, no overrun
                overrun <= pending && !pop;
            end else if (pop) begin
                pending <= 1'b0;
                overrun <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/tx_arbiter.sv
// Round-robin arbiter between host queue and alarm reporter
// Registers the serializer start together with a one-cycle grant pulse
module tx_arbiter (
    input  logic                   baud_clk,
    input  logic                   arst_n,
    input  uart_port_pkg::tx_req_t fifo_req,
    input  uart_port_pkg::tx_req_t alarm_req,
    input  logic                   busy,
    output uart_port_pkg::tx_req_t ser_req,
    output uart_port_pkg::grant_t  grant
);
    import uart_port_pkg::*;

    src_id_t last_win;       // Winner of the previous start
    src_id_t winner;         // Winner for this cycle
    logic    start_issued;   // Start out, busy not yet up
    logic    any_req;        // Someone is offering
    logic    can_start;      // Issue a start this edge

    assign any_req   = fifo_req.valid || alarm_req.valid;
    assign can_start = any_req && !busy && !start_issued;

    // Alternate on contention, else take whoever is valid
    always_comb begin
        if (fifo_req.valid && alarm_req.valid) begin
            winner = (last_win == SRC_HOST) ? SRC_ALARM : SRC_HOST;
        end else if (alarm_req.valid) begin
            winner = SRC_ALARM;
        end else begin
            winner = SRC_HOST;
        end
    end

    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            last_win     <= SRC_ALARM;   // Host goes first after reset
            start_issued <= 1'b0;
            ser_req      <= '0;
            grant        <= '0;
        end else begin
            start_issued  <= can_start;   // Blocks the cycle before busy rises
            ser_req.valid <= can_start;
            grant         <= '0;          // Pulse, one cycle only
            if (can_start) begin
                grant[winner] <= 1'b1;
                last_win      <= winner;
                ser_req.data  <= (winner == SRC_ALARM) ? alarm_req.data : fifo_req.data;
            end
        end
    end

    // Sources hold their offer until the grant reaches them
    a_grant_to_offer: assert property (
        @(posedge baud_clk) disable iff (!arst_n)
        (grant & ~{alarm_req.valid, fifo_req.valid}) == 2'b00
    ) else $error("tx_arbiter: grant to a source with no offer");

    // Queue head stays put until its pop, so the started byte matches it
    a_host_byte_started: assert property (
        @(posedge baud_clk) disable iff (!arst_n)
        grant[SRC_HOST] |-> (ser_req.data == fifo_req.data)
    ) else $error("tx_arbiter: started byte differs from queue head");

endmodule

// File: rtl/uart_tx.sv
// Serializer for 11-bit UART frames, one bit per baud_clk cycle
// Builds start, data, parity and stop, shifts LSB first
`include "uart_cfg.svh"

module uart_tx (
    input  logic                   baud_clk,
    input  logic                   arst_n,
    input  uart_port_pkg::tx_req_t ser_req,
    output logic                   tx,
    output logic                   busy
);
    import uart_frame_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BITS);

    ser_state_t       state;        // FSM state
    frame_word_t      frame;        // Shift register, bit 0 on the line
    logic [CNT_W-1:0] bit_cnt;      // Bits already on the line minus one
    logic             parity_bit;   // Parity of the incoming byte

    // Reduction XOR gives even parity, config flips it for odd
    assign parity_bit = (^ser_req.data) ^ `UART_PARITY_ODD;

    assign tx   = frame[0];              // Line follows frame LSB
    assign busy = (state == SER_SHIFT);  // High for the 11 bit cycles

    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= SER_IDLE;
            frame   <= '1;                  // Idle line is high
            bit_cnt <= '0;
        end else begin
            unique case (state)
                SER_IDLE: begin
                    if (ser_req.valid) begin
                        // Start bit lands on tx right after this edge
                        frame <= '{
                            stop:   1'b1,
                            parity: parity_bit,
                            data:   ser_req.data,
                            start:  1'b0
                        };
                        bit_cnt <= '0;
                        state   <= SER_SHIFT;
                    end
                end
                SER_SHIFT: begin
                    frame <= {1'b1, frame[FRAME_BITS-1:1]};  // Ones fill behind stop
                    if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                        state <= SER_IDLE;   // Stop bit just ended
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // Arbiter must hold off while a frame is on the line
    a_no_start_when_busy: assert property (
        @(posedge baud_clk) disable iff (!arst_n)
        busy |-> !ser_req.valid
    ) else $error("uart_tx: start request while busy");

endmodule

// File: rtl/uart_tx_top.sv
// UART transmit hub top level
// Host queue and alarm reporter share one serializer via the arbiter
module uart_tx_top (
    input  logic       baud_clk,
    input  logic       arst_n,
    input  logic [7:0] host_data,
    input  logic       host_wr,
    output logic       host_full,
    input  logic       alarm,
    input  logic [3:0] alarm_code,
    output logic       tx,
    output logic       busy
);
    import uart_port_pkg::*;

    tx_req_t fifo_req;    // Host queue head
    tx_req_t alarm_req;   // Pending alarm report
    tx_req_t ser_req;     // Start to the serializer
    grant_t  grant;       // Pop pulses back to the sources

    tx_fifo u_tx_fifo (
        .baud_clk  (baud_clk),
        .arst_n    (arst_n),
        .host_data (host_data),
        .host_wr   (host_wr),
        .pop       (grant[SRC_HOST]),
        .fifo_req  (fifo_req),
        .host_full (host_full)
    );

    alarm_reporter u_alarm_reporter (
        .baud_clk   (baud_clk),
        .arst_n     (arst_n),
        .alarm      (alarm),
        .alarm_code (alarm_code),
        .pop        (grant[SRC_ALARM]),
        .alarm_req  (alarm_req)
    );

    tx_arbiter u_tx_arbiter (
        .baud_clk  (baud_clk),
        .arst_n    (arst_n),
        .fifo_req  (fifo_req),
        .alarm_req (alarm_req),
        .busy      (busy),
        .ser_req   (ser_req),
        .grant     (grant)
    );

    uart_tx u_uart_tx (
        .baud_clk (baud_clk),
        .arst_n   (arst_n),
        .ser_req  (ser_req),
        .tx       (tx),
        .busy     (busy)
    );

endmodule

// File: bench/tb_uart_tx_top.sv
// Testbench for the UART transmit hub
// Clock, reset, stimulus, line decoder, reference parity, compare tasks, watchdog
`include "uart_cfg.svh"

module tb_uart_tx_top;
    timeunit 1ns;
    timeprecision 100ps;

    import uart_port_pkg::*;

    localparam int WATCHDOG_NS = 40 * 12 * 4 * 2;  // 40 frames of 12 cycles, doubled
    localparam int IDLE_CYCLES = 16;               // Quiet line after each test

    typedef struct packed {
        logic       start;
        logic [7:0] data;
        logic       parity;
        logic       stop;
        logic       busy_ok;   // busy high 11 cycles, then low
    } line_frame_t;

    logic       baud_clk;
    logic       arst_n;
    logic [7:0] host_data;
    logic       host_wr;
    logic       host_full;
    logic       alarm;
    logic [3:0] alarm_code;
    logic       tx;
    logic       busy;

    line_frame_t rx_q[$];    // Frames seen on tx
    logic [7:0]  exp_q[$];   // Bytes expected on tx, in order
    tx_req_t     hist_q[$];  // Every decoded frame as a request
    logic [31:0] rng;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;

    uart_tx_top dut_i (
        .baud_clk   (baud_clk),
        .arst_n     (arst_n),
        .host_data  (host_data),
        .host_wr    (host_wr),
        .host_full  (host_full),
        .alarm      (alarm),
        .alarm_code (alarm_code),
        .tx         (tx),
        .busy       (busy)
    );

    initial begin
        baud_clk = 1'b0;
        forever #2 baud_clk = ~baud_clk;   // 4 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    // Count the ones, set parity so the total is even, flip for odd mode
    function automatic logic ref_parity(input logic [7:0] b);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += int'(b[i]);
        end
        return logic'(ones % 2 == 1) ^ `UART_PARITY_ODD;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_req(input string name, input tx_req_t got, input tx_req_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%03h expected 0x%03h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Drive one write, leaves host_wr high for back-to-back use
    task automatic host_write(input logic [7:0] b, output logic accepted);
        @(posedge baud_clk);
        #1;
        host_data = b;
        host_wr   = 1'b1;
        accepted  = !host_full;   // Holds until the next edge
    endtask

    task automatic end_write();
        @(posedge baud_clk);
        #1;
        host_wr = 1'b0;
    endtask

    task automatic pulse_alarm(input logic [3:0] code);
        @(posedge baud_clk);
        #1;
        alarm      = 1'b1;
        alarm_code = code;
        @(posedge baud_clk);
        #1;
        alarm = 1'b0;
    endtask

    // Polls mid-cycle, away from the edge that updates busy
    task automatic wait_busy();
        while (busy !== 1'b1) @(negedge baud_clk);
    endtask

    // All expected frames out, then a quiet stretch to catch extras
    task automatic wait_drain();
        while (exp_q.size() != 0 || busy !== 1'b0) @(negedge baud_clk);
        repeat (IDLE_CYCLES) @(posedge baud_clk);
    endtask

    task automatic end_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // Line decoder, samples mid-bit on the falling clock edge
    initial begin : decode_proc
        line_frame_t f;
        logic        ok;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge tx);
            @(negedge baud_clk);
            f.start = tx;
            ok      = busy;
            for (int i = 0; i < 8; i++) begin
                @(negedge baud_clk);
                f.data[i] = tx;   // LSB first
                ok &= busy;
            end
            @(negedge baud_clk);
            f.parity = tx;
            ok &= busy;
            @(negedge baud_clk);
            f.stop = tx;
            ok &= busy;
            @(negedge baud_clk);
            ok &= !busy;        // Falls on the edge ending stop
            f.busy_ok = ok;
            rx_q.push_back(f);
        end
    end

    initial begin : compare_proc
        line_frame_t f;
        tx_req_t     r;
        logic [7:0]  exp_b;
        forever begin
            while (rx_q.size() == 0) @(posedge baud_clk);
            f = rx_q.pop_front();
            r.valid = !f.start && f.stop;
            r.data  = f.data;
            hist_q.push_back(r);
            if (exp_q.size() == 0) begin
                $display("Unexpected frame with data 0x%02h appeared on tx", f.data);
                err_cnt++;
            end else begin
                exp_b = exp_q.pop_front();
                check_byte("tx_data", f.data, exp_b);
                check_bit("tx_start", f.start, 1'b0);
                check_bit("tx_parity", f.parity, ref_parity(exp_b));
                check_bit("tx_stop", f.stop, 1'b1);
                check_bit("busy_window", f.busy_ok, 1'b1);
            end
        end
    end

    initial begin : watchdog_proc
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main_proc
        int         e0;
        int         base;
        logic       acc;
        logic       full_seen;
        logic [7:0] b;
        logic [7:0] hb[4];
        logic [3:0] c1;
        logic [3:0] c2;
        tx_req_t    exp_r;
        rng        = 32'h9955_4792;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        arst_n     = 1'b0;
        host_data  = 8'h00;
        host_wr    = 1'b0;
        alarm      = 1'b0;
        alarm_code = 4'h0;
        repeat (2) @(posedge baud_clk);
        #1;
        arst_n = 1'b1;

        // 1. Idle after reset
        e0 = err_cnt;
        repeat (6) begin
            @(negedge baud_clk);
            check_bit("tx", tx, 1'b1);
            check_bit("busy", busy, 1'b0);
            check_bit("host_full", host_full, 1'b0);
        end
        end_test("reset_idle", e0);

        // 2. Single host bytes, one at a time
        e0 = err_cnt;
        repeat (4) begin
            b = rand_byte();
            host_write(b, acc);
            if (acc) exp_q.push_back(b);
            else begin
                $display("Single host write of 0x%02h was refused", b);
                err_cnt++;
            end
            end_write();
            wait_drain();
        end
        end_test("single_bytes", e0);

        // 3. Burst of 12 writes on consecutive cycles
        e0 = err_cnt;
        full_seen = 1'b0;
        for (int i = 0; i < 12; i++) begin
            b = rand_byte();
            host_write(b, acc);
            if (acc) exp_q.push_back(b);   // Only accepted bytes go out
            else full_seen = 1'b1;
        end
        end_write();
        if (!full_seen) begin
            $display("host_full never rose during the 12-byte burst");
            err_cnt++;
        end
        wait_drain();
        end_test("burst_full", e0);

        // 4. One alarm with an empty host queue
        e0 = err_cnt;
        b  = rand_byte();
        c1 = b[7:4];
        exp_q.push_back({`UART_ALARM_TAG, c1});
        pulse_alarm(c1);
        wait_drain();
        end_test("alarm_report", e0);

        // 5. Two alarms while a host frame is on the line
        e0 = err_cnt;
        b  = rand_byte();
        c1 = b[3:0];
        c2 = c1 ^ 4'h5;   // Differs from the first code
        b  = rand_byte();
        host_write(b, acc);
        exp_q.push_back(b);
        end_write();
        exp_q.push_back({`UART_OVERRUN_TAG, c2});
        wait_busy();
        pulse_alarm(c1);
        pulse_alarm(c2);
        wait_drain();
        end_test("alarm_overrun", e0);

        // 6. Alarm competing with a loaded host queue
        e0   = err_cnt;
        base = hist_q.size();
        for (int i = 0; i < 4; i++) begin
            hb[i] = rand_byte();
            if (hb[i][7:4] == `UART_ALARM_TAG || hb[i][7:4] == `UART_OVERRUN_TAG) begin
                hb[i] = hb[i] ^ 8'h10;   // Keep host bytes apart from reports
            end
        end
        b  = rand_byte();
        c1 = b[7:4];
        exp_q.push_back(hb[0]);
        exp_q.push_back({`UART_ALARM_TAG, c1});
        for (int i = 1; i < 4; i++) begin
            exp_q.push_back(hb[i]);
        end
        for (int i = 0; i < 4; i++) begin
            host_write(hb[i], acc);
        end
        end_write();
        wait_busy();
        pulse_alarm(c1);
        wait_drain();
        exp_r.valid = 1'b1;
        exp_r.data  = {`UART_ALARM_TAG, c1};
        if (hist_q.size() < base + 2) begin
            $display("Contention test produced fewer than two frames");
            err_cnt++;
        end else begin
            check_req("second_frame", hist_q[base + 1], exp_r);
        end
        end_test("round_robin", e0);

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/uart_frame_pkg.sv
rtl/uart_port_pkg.sv
rtl/tx_fifo.sv
rtl/alarm_reporter.sv
rtl/tx_arbiter.sv
rtl/uart_tx.sv
rtl/uart_tx_top.sv
bench/tb_uart_tx_top.sv

// File: Makefile
# Verilator build and run for the UART transmit hub testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_uart_tx_top
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
